/* Makefile */
# Verilator build and run of the DMA control testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_dma_ctrl -Mdir obj_dir
	./obj_dir/Vtb_dma_ctrl +verilator+error+limit+100 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* design/axil_reg_port.sv */
// ----------------------------------------------------------------------
// register bus slave: write and read accept, response registers,
// access strobes to the register blocks and registered read data
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_ctrl_defs.svh"

module axil_reg_port
    import ctrl_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  reg_wr_req_t            wr_req,
    input  reg_rd_req_t            rd_req,
    output reg_wr_rsp_t            wr_rsp,
    output reg_rd_rsp_t            rd_rsp,
    output reg_access_t            access,
    input  logic [`REG_DATA_W-1:0] desc_rdata,
    input  logic [`REG_DATA_W-1:0] count_rdata
);

    logic                   wr_take;
    logic                   rd_take;
    logic                   awready_q;
    logic                   wready_q;
    logic                   bvalid_q;
    logic                   arready_q;
    logic                   rvalid_q;
    logic [`REG_DATA_W-1:0] rdata_q;

    // a held response blocks its own channel only
    assign wr_take = wr_req.awvalid && wr_req.wvalid && !bvalid_q;
    assign rd_take = rd_req.arvalid && !rvalid_q;

    assign access.wr_en   = wr_take;
    assign access.wr_addr = wr_req.awaddr;
    assign access.wr_data = wr_req.wdata;
    assign access.rd_en   = rd_take;
    assign access.rd_addr = rd_req.araddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            awready_q <= wr_take;
            wready_q  <= wr_take;
            bvalid_q  <= wr_take || (bvalid_q && !wr_req.bready);
            arready_q <= rd_take;
            rvalid_q  <= rd_take || (rvalid_q && !rd_req.rready);
        end
    end

    // blocks return zero off their own addresses
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata_q <= desc_rdata | count_rdata;
        end
    end

    assign wr_rsp.awready = awready_q;
    assign wr_rsp.wready  = wready_q;
    assign wr_rsp.bvalid  = bvalid_q;
    assign wr_rsp.bresp   = 2'b00;

    assign rd_rsp.arready = arready_q;
    assign rd_rsp.rvalid  = rvalid_q;
    assign rd_rsp.rdata   = rdata_q;
    assign rd_rsp.rresp   = 2'b00;

endmodule

`default_nettype wire

/* design/ctrl_bus_pkg.sv */
// ----------------------------------------------------------------------
// register bus request and response structs, register address union
// and the access strobes handed to the register blocks
// ----------------------------------------------------------------------
`default_nettype none

`include "dma_ctrl_defs.svh"

package ctrl_bus_pkg;

    // raw address, or decoded as block / word / byte
    typedef union packed {
        logic [`REG_ADDR_W-1:0] raw;
        struct packed {
            logic [7:0] block;
            logic [5:0] word;
            logic [1:0] byte_ofs;
        } f;
    } reg_addr_u;

    typedef struct packed {
        reg_addr_u              awaddr;
        logic [`REG_DATA_W-1:0] wdata;
        logic                   awvalid;
        logic                   wvalid;
        logic                   bready;
    } reg_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } reg_wr_rsp_t;

    typedef struct packed {
        reg_addr_u araddr;
        logic      arvalid;
        logic      rready;
    } reg_rd_req_t;

    typedef struct packed {
        logic                   arready;
        logic                   rvalid;
        logic [`REG_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } reg_rd_rsp_t;

    // one-cycle strobes in the accept cycle
    typedef struct packed {
        logic                   wr_en;
        reg_addr_u              wr_addr;
        logic [`REG_DATA_W-1:0] wr_data;
        logic                   rd_en;
        reg_addr_u              rd_addr;
    } reg_access_t;

endpackage

`default_nettype wire

/* design/dma_ctrl_top.sv */
// ----------------------------------------------------------------------
// DMA control top: register port, descriptor registers,
// packet counters and the two error pulse mergers
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_ctrl_defs.svh"

module dma_ctrl_top
    import ctrl_bus_pkg::*;
    import dma_desc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  reg_wr_req_t               wr_req,
    input  reg_rd_req_t               rd_req,
    output reg_wr_rsp_t               wr_rsp,
    output reg_rd_rsp_t               rd_rsp,
    output logic                      dma_enable,
    output dma_desc_t                 rd_desc,
    output logic                      rd_desc_valid,
    input  logic                      rd_desc_ready,
    output dma_desc_t                 wr_desc,
    output logic                      wr_desc_valid,
    input  logic                      wr_desc_ready,
    input  desc_status_t              rd_status,
    output logic                      rd_status_ready,
    input  desc_status_t              wr_status,
    output logic                      wr_status_ready,
    output logic                      irq,
    input  stream_obs_t               stream_obs,
    input  logic [`ERR_SRC_COUNT-1:0] err_cor,
    input  logic [`ERR_SRC_COUNT-1:0] err_uncor,
    output logic                      status_error_cor,
    output logic                      status_error_uncor
);

    reg_access_t            access;
    logic [`REG_DATA_W-1:0] desc_rdata;
    logic [`REG_DATA_W-1:0] count_rdata;

    axil_reg_port i_reg_port (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .rd_req(rd_req),
        .wr_rsp(wr_rsp), .rd_rsp(rd_rsp),
        .access(access),
        .desc_rdata(desc_rdata), .count_rdata(count_rdata)
    );

    dma_desc_regs i_desc_regs (
        .clk(clk), .rst(rst),
        .access(access), .rdata(desc_rdata),
        .dma_enable(dma_enable),
        .rd_desc(rd_desc), .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
        .wr_desc(wr_desc), .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready),
        .rd_status(rd_status), .rd_status_ready(rd_status_ready),
        .wr_status(wr_status), .wr_status_ready(wr_status_ready),
        .irq(irq)
    );

    pcie_pkt_counters i_counters (
        .clk(clk), .rst(rst),
        .access(access), .stream_obs(stream_obs), .rdata(count_rdata)
    );

    error_pulse_merge #(.INPUT_WIDTH(`ERR_SRC_COUNT)) i_err_cor (
        .clk(clk), .rst(rst), .pulse_in(err_cor), .pulse_out(status_error_cor)
    );

    error_pulse_merge #(.INPUT_WIDTH(`ERR_SRC_COUNT)) i_err_uncor (
        .clk(clk), .rst(rst), .pulse_in(err_uncor), .pulse_out(status_error_uncor)
    );

endmodule

`default_nettype wire

/* design/dma_desc_pkg.sv */
// ----------------------------------------------------------------------
// DMA descriptor, descriptor status and status word types,
// observed stream beats for the packet counters
// ----------------------------------------------------------------------
`default_nettype none

`include "dma_ctrl_defs.svh"

package dma_desc_pkg;

    typedef struct packed {
        logic [`PCIE_ADDR_W-1:0] pcie_addr;
        logic [`AXI_ADDR_W-1:0]  axi_addr;
        logic [`DMA_LEN_W-1:0]   len;
        logic [`DMA_TAG_W-1:0]   tag;
    } dma_desc_t;

    typedef struct packed {
        logic [`DMA_TAG_W-1:0] tag;
        logic                  valid;
    } desc_status_t;

    // pending flag in bit 31
    typedef struct packed {
        logic                                 pending;
        logic [`REG_DATA_W-`DMA_TAG_W-2:0]    reserved;
        logic [`DMA_TAG_W-1:0]                tag;
    } status_word_t;

    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } stream_beat_t;

    typedef struct packed {
        stream_beat_t rq;
        stream_beat_t rc;
        stream_beat_t cq;
        stream_beat_t cc;
    } stream_obs_t;

endpackage

`default_nettype wire

/* design/dma_desc_regs.sv */
// ----------------------------------------------------------------------
// DMA enable, read and write descriptor registers with issue valid,
// clear-on-read descriptor status and interrupt level
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_ctrl_defs.svh"

module dma_desc_regs
    import ctrl_bus_pkg::*;
    import dma_desc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  reg_access_t            access,
    output logic [`REG_DATA_W-1:0] rdata,
    output logic                   dma_enable,
    output dma_desc_t              rd_desc,
    output logic                   rd_desc_valid,
    input  logic                   rd_desc_ready,
    output dma_desc_t              wr_desc,
    output logic                   wr_desc_valid,
    input  logic                   wr_desc_ready,
    input  desc_status_t           rd_status,
    output logic                   rd_status_ready,
    input  desc_status_t           wr_status,
    output logic                   wr_status_ready,
    output logic                   irq
);

    logic ctrl_wr;
    logic rd_blk_wr;
    logic wr_blk_wr;
    logic rd_tag_wr;
    logic wr_tag_wr;
    logic rd_stat_rd;
    logic wr_stat_rd;

    function automatic dma_desc_t desc_update(dma_desc_t cur, logic [5:0] word,
                                              logic [`REG_DATA_W-1:0] data);
        dma_desc_t d;
        d = cur;
        case (word)
            `OFS_PCIE_LO: d.pcie_addr[31:0] = data;
            `OFS_PCIE_HI: d.pcie_addr[`PCIE_ADDR_W-1:32] = data;
            `OFS_AXI:     d.axi_addr = data[`AXI_ADDR_W-1:0];
            `OFS_LEN:     d.len = data[`DMA_LEN_W-1:0];
            `OFS_TAG:     d.tag = data[`DMA_TAG_W-1:0];
            default:      ;
        endcase
        return d;
    endfunction

    function automatic status_word_t status_word(desc_status_t st);
        status_word_t w;
        w = '0;
        w.pending = st.valid;
        w.tag = st.tag;
        return w;
    endfunction

    // write decode, byte bits ignored
    assign ctrl_wr   = access.wr_en && access.wr_addr.f.block == `BLK_CTRL
                       && access.wr_addr.f.word == 6'd0;
    assign rd_blk_wr = access.wr_en && access.wr_addr.f.block == `BLK_RD_DESC;
    assign wr_blk_wr = access.wr_en && access.wr_addr.f.block == `BLK_WR_DESC;
    assign rd_tag_wr = rd_blk_wr && access.wr_addr.f.word == `OFS_TAG;
    assign wr_tag_wr = wr_blk_wr && access.wr_addr.f.word == `OFS_TAG;

    assign rd_stat_rd = access.rd_addr.f.block == `BLK_RD_DESC
                        && access.rd_addr.f.word == `OFS_STATUS;
    assign wr_stat_rd = access.rd_addr.f.block == `BLK_WR_DESC
                        && access.rd_addr.f.word == `OFS_STATUS;

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable      <= 1'b0;
            rd_desc_valid   <= 1'b0;
            wr_desc_valid   <= 1'b0;
            rd_status_ready <= 1'b0;
            wr_status_ready <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                dma_enable <= access.wr_data[0];
            end
            // tag write issues, a fresh tag wins over ready
            rd_desc_valid   <= rd_tag_wr || (rd_desc_valid && !rd_desc_ready);
            wr_desc_valid   <= wr_tag_wr || (wr_desc_valid && !wr_desc_ready);
            // ack only what was seen pending
            rd_status_ready <= access.rd_en && rd_stat_rd && rd_status.valid;
            wr_status_ready <= access.rd_en && wr_stat_rd && wr_status.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_blk_wr) begin
            rd_desc <= desc_update(rd_desc, access.wr_addr.f.word, access.wr_data);
        end
        if (wr_blk_wr) begin
            wr_desc <= desc_update(wr_desc, access.wr_addr.f.word, access.wr_data);
        end
    end

    always_comb begin
        rdata = '0;
        if (access.rd_addr.f.block == `BLK_CTRL && access.rd_addr.f.word == 6'd0) begin
            rdata = {{(`REG_DATA_W-1){1'b0}}, dma_enable};
        end else if (rd_stat_rd) begin
            rdata = status_word(rd_status);
        end else if (wr_stat_rd) begin
            rdata = status_word(wr_status);
        end
    end

    assign irq = rd_status.valid || wr_status.valid;

endmodule

`default_nettype wire

/* design/error_pulse_merge.sv */
// ----------------------------------------------------------------------
// error pulse merge: counts set inputs, replays them as single
// registered pulses, one per cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_ctrl_defs.svh"

module error_pulse_merge #(
    parameter int INPUT_WIDTH = `ERR_SRC_COUNT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INPUT_WIDTH-1:0] pulse_in,
    output logic                   pulse_out
);

    logic [`ERR_CNT_W-1:0] count_q;
    logic [`ERR_CNT_W-1:0] in_count;
    logic                  drain;

    // population of this cycle's inputs
    always_comb begin
        in_count = '0;
        for (int i = 0; i < INPUT_WIDTH; i++) begin
            in_count = in_count + {{(`ERR_CNT_W-1){1'b0}}, pulse_in[i]};
        end
    end

    assign drain = |count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q   <= '0;
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= drain;
            count_q   <= count_q + in_count - {{(`ERR_CNT_W-1){1'b0}}, drain};
        end
    end

endmodule

`default_nettype wire

/* design/pcie_pkt_counters.sv */
// ----------------------------------------------------------------------
// completed packet counters on the RQ, RC, CQ and CC streams
// and their register readback
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_ctrl_defs.svh"

module pcie_pkt_counters
    import ctrl_bus_pkg::*;
    import dma_desc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  reg_access_t            access,
    input  stream_obs_t            stream_obs,
    output logic [`REG_DATA_W-1:0] rdata
);

    logic [`REG_DATA_W-1:0] count_q [4];
    logic [3:0]             pkt_done;

    function automatic logic beat_done(stream_beat_t b);
        return b.valid && b.ready && b.last;
    endfunction

    // word order rq, rc, cq, cc
    assign pkt_done = {beat_done(stream_obs.cc), beat_done(stream_obs.cq),
                       beat_done(stream_obs.rc), beat_done(stream_obs.rq)};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (pkt_done[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (access.rd_addr.f.block == `BLK_COUNT && access.rd_addr.f.word[5:2] == 4'd0) begin
            rdata = count_q[access.rd_addr.f.word[1:0]];
        end
    end

endmodule

`default_nettype wire

/* include/dma_ctrl_defs.svh */
// ----------------------------------------------------------------------
// DMA control block widths, register block codes and word offsets
// within a register block, error merge counter width
// ----------------------------------------------------------------------
`ifndef DMA_CTRL_DEFS_SVH
`define DMA_CTRL_DEFS_SVH

// register bus
`define REG_DATA_W 32
`define REG_ADDR_W 16

// descriptor fields
`define PCIE_ADDR_W 64
`define AXI_ADDR_W 32
`define DMA_LEN_W 16
`define DMA_TAG_W 8

// error pulse merge
`define ERR_SRC_COUNT 3
`define ERR_CNT_W 4

// register blocks, address bits 15:8
`define BLK_CTRL 8'h00
`define BLK_RD_DESC 8'h01
`define BLK_WR_DESC 8'h02
`define BLK_COUNT 8'h04

// word offsets inside a descriptor block
`define OFS_PCIE_LO 6'd0
`define OFS_PCIE_HI 6'd1
`define OFS_AXI 6'd2
`define OFS_LEN 6'd4
`define OFS_TAG 6'd5
`define OFS_STATUS 6'd6

`endif

/* sim.f */
+incdir+include
design/ctrl_bus_pkg.sv
design/dma_desc_pkg.sv
design/axil_reg_port.sv
design/dma_desc_regs.sv
design/pcie_pkt_counters.sv
design/error_pulse_merge.sv
design/dma_ctrl_top.sv
tests/dma_ctrl_sva.sv
tests/tb_dma_ctrl.sv

/* tests/dma_ctrl_sva.sv */
// ----------------------------------------------------------------------
// concurrent protocol checks on the register bus, descriptor issue
// and status acknowledge, bound into the DMA control top
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_sva
    import ctrl_bus_pkg::*;
    import dma_desc_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input reg_wr_req_t wr_req,
    input reg_rd_req_t rd_req,
    input reg_wr_rsp_t wr_rsp,
    input reg_rd_rsp_t rd_rsp,
    input dma_desc_t   rd_desc,
    input logic        rd_desc_valid,
    input logic        rd_desc_ready,
    input dma_desc_t   wr_desc,
    input logic        wr_desc_valid,
    input logic        wr_desc_ready,
    input logic        rd_status_ready,
    input logic        wr_status_ready
);

    int assert_fails = 0;

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid)
        else begin
            assert_fails++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.rdata))
        else begin
            assert_fails++;
            $error("read response changed before rready");
        end

    rd_desc_hold: assert property (@(posedge clk) disable iff (rst)
        rd_desc_valid && !rd_desc_ready |=> rd_desc_valid && $stable(rd_desc))
        else begin
            assert_fails++;
            $error("read descriptor changed before ready");
        end

    wr_desc_hold: assert property (@(posedge clk) disable iff (rst)
        wr_desc_valid && !wr_desc_ready |=> wr_desc_valid && $stable(wr_desc))
        else begin
            assert_fails++;
            $error("write descriptor changed before ready");
        end

    // status acks are single-cycle
    rd_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        rd_status_ready |=> !rd_status_ready)
        else begin
            assert_fails++;
            $error("rd_status_ready longer than one cycle");
        end

    wr_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        wr_status_ready |=> !wr_status_ready)
        else begin
            assert_fails++;
            $error("wr_status_ready longer than one cycle");
        end

    // both readies pulse in the cycle bvalid rises
    aw_w_ready: assert property (@(posedge clk) disable iff (rst)
        wr_rsp.awready || wr_rsp.wready |->
            wr_rsp.awready && wr_rsp.wready && $rose(wr_rsp.bvalid))
        else begin
            assert_fails++;
            $error("awready and wready out of step with the write accept");
        end

endmodule

bind dma_ctrl_top dma_ctrl_sva i_sva (
    .clk(clk), .rst(rst),
    .wr_req(wr_req), .rd_req(rd_req), .wr_rsp(wr_rsp), .rd_rsp(rd_rsp),
    .rd_desc(rd_desc), .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
    .wr_desc(wr_desc), .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready),
    .rd_status_ready(rd_status_ready), .wr_status_ready(wr_status_ready)
);

`default_nettype wire

/* tests/tb_dma_ctrl.sv */
// ----------------------------------------------------------------------
// testbench for the DMA control top with register bus tasks and the
// descriptor, status, counter and error merge tests, closing summary
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dma_ctrl_defs.svh"

module tb_dma_ctrl
    import ctrl_bus_pkg::*;
    import dma_desc_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic         clk;
    logic         rst;
    reg_wr_req_t  wr_req;
    reg_rd_req_t  rd_req;
    reg_wr_rsp_t  wr_rsp;
    reg_rd_rsp_t  rd_rsp;
    logic         dma_enable;
    dma_desc_t    rd_desc;
    dma_desc_t    wr_desc;
    logic         rd_desc_valid;
    logic         wr_desc_valid;
    logic         rd_desc_ready;
    logic         wr_desc_ready;
    desc_status_t rd_status;
    desc_status_t wr_status;
    logic         rd_status_ready;
    logic         wr_status_ready;
    logic         irq;
    stream_obs_t  stream_obs;
    logic [2:0]   err_cor;
    logic [2:0]   err_uncor;
    logic         status_error_cor;
    logic         status_error_uncor;

    int seed = 32'h4e0fcec0;
    int pass_count = 0;
    int fail_count = 0;
    int test_fails = 0;
    bit timed_out = 1'b0;
    int rd_acks = 0;
    int wr_acks = 0;
    int cor_pulses = 0;
    int uncor_pulses = 0;

    dma_ctrl_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // acks and error pulses sampled mid-cycle
    always @(negedge clk) begin
        if (rd_status_ready) rd_acks++;
        if (wr_status_ready) wr_acks++;
        if (status_error_cor) cor_pulses++;
        if (status_error_uncor) uncor_pulses++;
    end

    always @(posedge clk) begin
        if (timed_out) begin
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check(input bit ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            test_fails++;
        end
    endtask

    // stalls here until the clocked block above ends the run
    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        timed_out = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (test_fails == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d checks failed", name, test_fails);
        end
        test_fails = 0;
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        int n;
        wr_req.awaddr  = addr;
        wr_req.wdata   = data;
        wr_req.awvalid = 1'b1;
        wr_req.wvalid  = 1'b1;
        wr_req.bready  = 1'b1;
        n = 0;
        next_cycle();
        while (!wr_rsp.bvalid) begin
            if (n == TIMEOUT) report_timeout("the register write was never answered");
            next_cycle();
            n++;
        end
        check(wr_rsp.awready && wr_rsp.wready,
              $sformatf("awready or wready low as bvalid rose on write to %h", addr));
        check(wr_rsp.bresp == 2'b00, $sformatf("bresp %0d on write to %h", wr_rsp.bresp, addr));
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        next_cycle();
        wr_req.bready = 1'b0;
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [31:0] data);
        int n;
        rd_req.araddr  = addr;
        rd_req.arvalid = 1'b1;
        rd_req.rready  = 1'b0;
        n = 0;
        next_cycle();
        while (!rd_rsp.rvalid) begin
            if (n == TIMEOUT) report_timeout("the register read was never answered");
            next_cycle();
            n++;
        end
        check(rd_rsp.arready, $sformatf("arready low as rvalid rose on read of %h", addr));
        check(rd_rsp.rresp == 2'b00, $sformatf("rresp %0d on read of %h", rd_rsp.rresp, addr));
        data = rd_rsp.rdata;
        rd_req.arvalid = 1'b0;
        rd_req.rready  = 1'b1;
        next_cycle();
        rd_req.rready = 1'b0;
    endtask

    task automatic reset_test();
        logic [31:0] d;
        logic [31:0] r;
        check(!wr_rsp.awready && !wr_rsp.wready && !wr_rsp.bvalid, "write response high");
        check(!rd_rsp.arready && !rd_rsp.rvalid, "read response high after reset");
        check(!rd_desc_valid && !wr_desc_valid, "descriptor valid high after reset");
        check(!rd_status_ready && !wr_status_ready, "status ready high after reset");
        check(!dma_enable && !status_error_cor && !status_error_uncor, "enable or error high");
        reg_read({`BLK_CTRL, 6'd0, 2'b00}, d);
        check(d == 32'h0, $sformatf("control word %h after reset, expected 0", d));
        reg_write({`BLK_CTRL, 6'd0, 2'b00}, 32'h1);
        check(dma_enable, "dma_enable low after writing 1");
        reg_read({`BLK_CTRL, 6'd0, 2'b00}, d);
        check(d == 32'h1, $sformatf("control word %h, expected 1", d));
        r = rand32();
        reg_write(16'h3000, r);
        reg_read(16'h3000, d);
        check(d == 32'h0, $sformatf("unmapped word reads %h, expected 0", d));
    endtask

    task automatic desc_test(input bit is_wr);
        logic [7:0]  blk;
        dma_desc_t   exp;
        logic [31:0] r;
        int          hold;
        string       name;
        blk  = is_wr ? `BLK_WR_DESC : `BLK_RD_DESC;
        name = is_wr ? "write" : "read";
        exp.pcie_addr[31:0]  = rand32();
        exp.pcie_addr[63:32] = rand32();
        exp.axi_addr = rand32();
        r = rand32();
        exp.len = r[15:0];
        exp.tag = r[23:16];
        reg_write({blk, `OFS_PCIE_LO, 2'b00}, exp.pcie_addr[31:0]);
        reg_write({blk, `OFS_PCIE_HI, 2'b00}, exp.pcie_addr[63:32]);
        reg_write({blk, `OFS_AXI, 2'b00}, exp.axi_addr);
        reg_write({blk, `OFS_LEN, 2'b00}, {16'h0, exp.len});
        reg_write({blk, `OFS_TAG, 2'b00}, {24'h0, exp.tag});
        r = rand32();
        hold = 2 + int'(r[2:0]);
        for (int i = 0; i < hold; i++) begin
            check((is_wr ? wr_desc_valid : rd_desc_valid), {name, " descriptor valid dropped"});
            check((is_wr ? wr_desc : rd_desc) == exp,
                  $sformatf("%s descriptor %h, expected %h", name,
                            is_wr ? wr_desc : rd_desc, exp));
            check(!(is_wr ? rd_desc_valid : wr_desc_valid), "other descriptor valid rose");
            // the other channel's ready must leave this one alone
            if (is_wr) rd_desc_ready = 1'b1; else wr_desc_ready = 1'b1;
            next_cycle();
        end
        rd_desc_ready = !is_wr;
        wr_desc_ready = is_wr;
        next_cycle();
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        check(!rd_desc_valid && !wr_desc_valid, {name, " descriptor valid held after ready"});
    endtask

    task automatic status_test(input bit is_wr);
        logic [7:0]   blk;
        logic [31:0]  r;
        logic [31:0]  d;
        desc_status_t st;
        int           acks;
        blk = is_wr ? `BLK_WR_DESC : `BLK_RD_DESC;
        r = rand32();
        st.tag   = r[7:0];
        st.valid = 1'b1;
        if (is_wr) wr_status = st; else rd_status = st;
        next_cycle();
        check(irq, "irq low with a status pending");
        acks = is_wr ? wr_acks : rd_acks;
        reg_read({blk, `OFS_STATUS, 2'b00}, d);
        next_cycle();
        check(d == {1'b1, 23'h0, st.tag}, $sformatf("status word %h, tag %h pending", d, st.tag));
        check((is_wr ? wr_acks : rd_acks) == acks + 1, "status ready did not pulse once");
        st.valid = 1'b0;
        if (is_wr) wr_status = st; else rd_status = st;
        next_cycle();
        check(!irq, "irq high with no status pending");
        reg_read({blk, `OFS_STATUS, 2'b00}, d);
        next_cycle();
        check(d == {1'b0, 23'h0, st.tag}, $sformatf("status word %h, tag %h idle", d, st.tag));
        check((is_wr ? wr_acks : rd_acks) == acks + 1, "status ready pulsed with nothing pending");
    endtask

    task automatic counter_test();
        int          exp_cnt [4];
        logic [31:0] r;
        logic [31:0] d;
        for (int i = 0; i < 4; i++) exp_cnt[i] = 0;
        for (int c = 0; c < 200; c++) begin
            r = rand32();
            stream_obs = r[11:0];
            // rq sits in the top three bits in valid ready last order
            for (int i = 0; i < 4; i++) begin
                if (&r[11 - 3 * i -: 3]) exp_cnt[i]++;
            end
            next_cycle();
        end
        stream_obs = '0;
        next_cycle();
        for (int i = 0; i < 4; i++) begin
            reg_read({`BLK_COUNT, 6'(i), 2'b00}, d);
            check(d == exp_cnt[i], $sformatf("counter %0d reads %0d, expected %0d", i, d, exp_cnt[i]));
        end
    endtask

    task automatic error_test();
        int          exp_cor;
        int          exp_uncor;
        int          cor0;
        int          uncor0;
        int          len;
        int          quiet;
        int          n;
        logic [31:0] r;
        cor0 = cor_pulses;
        uncor0 = uncor_pulses;
        exp_cor = 0;
        exp_uncor = 0;
        for (int b = 0; b < 8; b++) begin
            r = rand32();
            len = 1 + int'(r[1:0]);
            for (int c = 0; c < len; c++) begin
                r = rand32();
                err_cor = r[2:0];
                err_uncor = r[6:4];
                exp_cor += $countones(r[2:0]);
                exp_uncor += $countones(r[6:4]);
                next_cycle();
            end
            err_cor = '0;
            err_uncor = '0;
            quiet = 0;
            n = 0;
            while (quiet < 20) begin
                if (n == TIMEOUT) report_timeout("the error pulse outputs never went quiet");
                quiet = (status_error_cor || status_error_uncor) ? 0 : quiet + 1;
                next_cycle();
                n++;
            end
        end
        check(cor_pulses - cor0 == exp_cor,
              $sformatf("%0d correctable pulses, expected %0d", cor_pulses - cor0, exp_cor));
        check(uncor_pulses - uncor0 == exp_uncor,
              $sformatf("%0d uncorrectable pulses, expected %0d", uncor_pulses - uncor0, exp_uncor));
    endtask

    initial begin
        rst = 1'b1;
        wr_req = '0;
        rd_req = '0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status = '0;
        wr_status = '0;
        stream_obs = '0;
        err_cor = '0;
        err_uncor = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_test();
        end_test("reset and enable");
        desc_test(1'b0);
        end_test("read descriptor");
        desc_test(1'b1);
        end_test("write descriptor");
        status_test(1'b0);
        status_test(1'b1);
        end_test("descriptor status");
        counter_test();
        end_test("packet counters");
        error_test();
        end_test("error merge");
        if (i_dut.i_sva.assert_fails != 0) begin
            $display("concurrent assertions failed %0d times", i_dut.i_sva.assert_fails);
            fail_count++;
        end
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
